/* tcp_conn_pkg.sv */
package tcp_conn_pkg;

  typedef logic [31:0] tcp_num_t;
  typedef logic [15:0] tcp_port_t;
  typedef logic [31:0] ipv4_addr_t;

  // flags byte, tested whole or bit by bit
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic cwr;
      logic ece;
      logic urg;
      logic ack;
      logic psh;
      logic rst;
      logic syn;
      logic fin;
    } bits;
  } tcp_flags_u;

  localparam logic [7:0] FLAG_FIN = 8'h01;
  localparam logic [7:0] FLAG_SYN = 8'h02;
  localparam logic [7:0] FLAG_RST = 8'h04;
  localparam logic [7:0] FLAG_ACK = 8'h10;

  typedef struct packed {
    logic       val;      // one cycle strobe
    ipv4_addr_t src_ip;
    tcp_port_t  src_port;
    tcp_port_t  dst_port;
    tcp_num_t   seq;
    tcp_num_t   ack;
    tcp_flags_u flags;
    logic [15:0] pld_len;
  } rx_seg_t;

  typedef struct packed {
    ipv4_addr_t dst_ip;
    tcp_port_t  src_port;
    tcp_port_t  dst_port;
    tcp_num_t   seq;
    tcp_num_t   ack;
    tcp_flags_u flags;
    logic [15:0] wnd;
    logic [3:0] offset;   // header length in 32-bit words
    logic [3:0] rsvd;
  } tx_seg_t;

  typedef enum logic [2:0] {
    seg_syn,
    seg_syn_ack,
    seg_ack,
    seg_fin_ack,
    seg_rst_ack
  } seg_kind_e;

  typedef struct packed {
    logic       connect;
    logic       listen;
    tcp_port_t  loc_port;
    tcp_port_t  rem_port;
    ipv4_addr_t rem_ip;
    tcp_num_t   loc_isn;
    logic [31:0] timeout;  // in clock cycles
  } conn_cfg_t;

  typedef struct packed {
    ipv4_addr_t rem_ip;
    tcp_port_t  loc_port;
    tcp_port_t  rem_port;
    tcp_num_t   loc_seq;
    tcp_num_t   loc_ack;
    tcp_num_t   rem_ack;
  } tcb_t;

  typedef enum logic [2:0] {
    st_closed,
    st_listening,
    st_connecting,
    st_connected,
    st_disconnecting
  } conn_state_e;

  typedef struct packed {
    logic syn_rec;
    logic syn_ack_rec;
    logic ack_rec;
    logic fin_rec;
    logic rst_rec;
    logic ack_flag;
    logic port_ok;
  } seg_match_t;

  //////////////////////////////
  // register map
  //////////////////////////////
  localparam logic [2:0] REG_CTRL    = 3'd0;
  localparam logic [2:0] REG_PORTS   = 3'd1;
  localparam logic [2:0] REG_REM_IP  = 3'd2;
  localparam logic [2:0] REG_ISN     = 3'd3;
  localparam logic [2:0] REG_TIMEOUT = 3'd4;
  localparam logic [2:0] REG_STATUS  = 3'd5; // read only from here up
  localparam logic [2:0] REG_LOC_SEQ = 3'd6;
  localparam logic [2:0] REG_REM_ACK = 3'd7;

endpackage

/* tcp_conn_regs.sv */
`timescale 1ns/1ps

module tcp_conn_regs (
  input  logic                      clk,
  input  logic                      rst_rec,
  input  logic                      cfg_wr,
  input  logic [2:0]                cfg_addr,
  input  logic [31:0]               cfg_wdata,
  output logic [31:0]               cfg_rdata,
  input  tcp_conn_pkg::conn_state_e state,
  input  tcp_conn_pkg::tcb_t        tcb,
  output tcp_conn_pkg::conn_cfg_t   cfg
);
  import tcp_conn_pkg::*;

  always_ff @(posedge clk) begin
    if (rst_rec) begin
      cfg <= '0;
    end else if (cfg_wr) begin
      case (cfg_addr)
        REG_CTRL: begin
          cfg.connect <= cfg_wdata[0];
          cfg.listen  <= cfg_wdata[1];
        end
        REG_PORTS: begin
          cfg.loc_port <= cfg_wdata[31:16];
          cfg.rem_port <= cfg_wdata[15:0];
        end
        REG_REM_IP:  cfg.rem_ip  <= cfg_wdata;
        REG_ISN:     cfg.loc_isn <= cfg_wdata;
        REG_TIMEOUT: cfg.timeout <= cfg_wdata;
        default: ; // status words
      endcase
    end
  end

  // readback mux
  always_comb begin
    case (cfg_addr)
      REG_CTRL:    cfg_rdata = {30'd0, cfg.listen, cfg.connect};
      REG_PORTS:   cfg_rdata = {cfg.loc_port, cfg.rem_port};
      REG_REM_IP:  cfg_rdata = cfg.rem_ip;
      REG_ISN:     cfg_rdata = cfg.loc_isn;
      REG_TIMEOUT: cfg_rdata = cfg.timeout;
      REG_STATUS:  cfg_rdata = {29'd0, state};
      REG_LOC_SEQ: cfg_rdata = tcb.loc_seq;
      default:     cfg_rdata = tcb.rem_ack;
    endcase
  end

  // host never writes the status words
  a_ro_wr: assert property (@(posedge clk) disable iff (rst_rec)
    cfg_wr |-> (cfg_addr < REG_STATUS));

endmodule

/* tcp_seg_match.sv */
`timescale 1ns/1ps

module tcp_seg_match (
  input  tcp_conn_pkg::rx_seg_t    rx,
  input  tcp_conn_pkg::conn_cfg_t  cfg,
  input  tcp_conn_pkg::tcb_t       tcb,
  output tcp_conn_pkg::seg_match_t match
);
  import tcp_conn_pkg::*;

  logic loc_port_ok; // segment aimed at the configured local port
  logic conn_ok;     // segment belongs to the current connection
  logic f_ack;
  logic f_syn;
  logic f_fin;
  logic f_rst;

  assign loc_port_ok = rx.val && (rx.dst_port == cfg.loc_port);
  assign conn_ok     = rx.val && (rx.src_port == tcb.rem_port) &&
                       (rx.dst_port == tcb.loc_port);

  //////////////////////////////
  // flag decode
  //////////////////////////////
  assign f_ack = rx.flags.bits.ack;
  assign f_syn = rx.flags.bits.syn;
  assign f_fin = rx.flags.bits.fin;
  assign f_rst = rx.flags.bits.rst;

  always_comb begin
    // connection request carries SYN and nothing else
    match.syn_rec     = loc_port_ok && (rx.flags.raw == FLAG_SYN);
    match.syn_ack_rec = loc_port_ok && f_syn && f_ack;

    match.port_ok     = conn_ok;
    match.ack_flag    = conn_ok && f_ack;

    // in order ack, closes the passive open
    match.ack_rec     = conn_ok && f_ack && (rx.seq == tcb.loc_ack);

    match.fin_rec     = conn_ok && f_fin;
    match.rst_rec     = conn_ok && f_rst;
  end

endmodule

/* tcp_conn_fsm.sv */
`timescale 1ns/1ps

module tcp_conn_fsm #(
  parameter int TMR_W = 32
) (
  input  logic                      clk,
  input  logic                      rst_rec,
  input  tcp_conn_pkg::conn_cfg_t   cfg,
  input  tcp_conn_pkg::seg_match_t  match,
  input  tcp_conn_pkg::rx_seg_t     rx,
  input  logic                      sent,
  input  logic                      busy,
  output logic                      send,
  output tcp_conn_pkg::seg_kind_e   kind,
  output tcp_conn_pkg::conn_state_e state,
  output tcp_conn_pkg::tcb_t        tcb
);
  import tcp_conn_pkg::*;

  enum logic [3:0] {
    closed_s, listen_s,
    syn_s, syn_sent_s, ack_s, ack_sent_s,  // active open
    syn_ack_s, syn_ack_sent_s,             // passive open
    est_s,
    fin_s, fin_sent_s, lack_s, lack_sent_s,
    rst_s, rst_sent_s
  } fsm;

  logic srv;       // opened by listen
  logic pas_cls;   // peer started the close
  logic ack_seen;  // our FIN got acked
  logic usr_dcn;
  logic can_send;
  logic tmr_en;
  logic tmo;
  logic [TMR_W-1:0] tmr;
  tcp_num_t ack_dif;

  assign usr_dcn  = srv ? !cfg.listen : !cfg.connect;
  assign can_send = !send && !busy;
  assign ack_dif  = rx.ack - tcb.rem_ack;

  always_comb begin
    case (fsm)
      closed_s: state = st_closed;
      listen_s: state = st_listening;
      est_s:    state = st_connected;
      syn_s, syn_sent_s, ack_s, ack_sent_s,
      syn_ack_s, syn_ack_sent_s: state = st_connecting;
      default:  state = st_disconnecting;
    endcase
  end

  //////////////////////////////
  // connect / disconnect timer
  //////////////////////////////
  assign tmr_en = (state == st_connecting) || (state == st_disconnecting);
  assign tmo    = tmr_en && (tmr == TMR_W'(cfg.timeout));

  always_ff @(posedge clk) begin
    if (rst_rec || !tmr_en) tmr <= '0;
    else                    tmr <= tmr + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst_rec) begin
      fsm      <= closed_s;
      tcb      <= '0;
      send     <= 1'b0;
      kind     <= seg_syn;
      srv      <= 1'b0;
      pas_cls  <= 1'b0;
      ack_seen <= 1'b0;
    end else begin
      if (sent) send <= 1'b0; // request done
      case (fsm)
        closed_s: begin
          pas_cls  <= 1'b0;
          ack_seen <= 1'b0;
          if (cfg.listen) begin
            srv <= 1'b1;
            fsm <= listen_s;
          end else if (cfg.connect) begin
            srv          <= 1'b0;
            tcb.rem_ip   <= cfg.rem_ip;
            tcb.loc_port <= cfg.loc_port;
            tcb.rem_port <= cfg.rem_port;
            tcb.loc_seq  <= cfg.loc_isn;
            tcb.loc_ack  <= '0;
            fsm          <= syn_s;
          end
        end
        syn_s: if (can_send) begin
          send <= 1'b1;
          kind <= seg_syn;
          fsm  <= syn_sent_s;
        end
        syn_sent_s: if (match.syn_ack_rec) begin
          tcb.loc_seq <= tcb.loc_seq + 1;
          tcb.loc_ack <= rx.seq + 1;
          tcb.rem_ack <= rx.ack;
          fsm         <= ack_s;
        end
        ack_s: if (can_send) begin
          send <= 1'b1;
          kind <= seg_ack;
          fsm  <= ack_sent_s;
        end
        ack_sent_s: if (sent) fsm <= est_s;
        listen_s: begin
          if (!cfg.listen) begin
            fsm <= closed_s;
          end else if (match.syn_rec) begin
            tcb.rem_ip   <= rx.src_ip;
            tcb.rem_port <= rx.src_port;
            tcb.loc_port <= cfg.loc_port;
            tcb.loc_seq  <= cfg.loc_isn;
            tcb.loc_ack  <= rx.seq + 1;
            tcb.rem_ack  <= rx.ack;
            fsm          <= syn_ack_s;
          end
        end
        syn_ack_s: if (can_send) begin
          send <= 1'b1;
          kind <= seg_syn_ack;
          fsm  <= syn_ack_sent_s;
        end
        syn_ack_sent_s: if (match.ack_rec) begin
          tcb.loc_seq <= tcb.loc_seq + 1;
          tcb.rem_ack <= rx.ack;
          fsm         <= est_s;
        end
        //////////////////////////////
        // established
        //////////////////////////////
        est_s: begin
          if (match.port_ok) begin
            if (match.ack_flag && !ack_dif[31]) tcb.rem_ack <= rx.ack; // only forward
            if (match.ack_rec) tcb.loc_ack <= tcb.loc_ack + rx.pld_len; // in order payload
          end
          if (usr_dcn) begin
            fsm <= fin_s;
          end else if (match.fin_rec) begin
            pas_cls     <= 1'b1;
            tcb.loc_ack <= tcb.loc_ack + 1; // FIN takes one number
            fsm         <= lack_s;
          end else if (match.rst_rec) begin
            fsm <= rst_s;
          end
        end
        fin_s: if (can_send) begin
          send     <= 1'b1;
          kind     <= seg_fin_ack;
          ack_seen <= 1'b0;
          fsm      <= fin_sent_s;
        end
        fin_sent_s: begin
          if (pas_cls) begin
            if (match.ack_flag) begin
              tcb <= '0;
              fsm <= closed_s;
            end
          end else begin
            if (match.ack_flag) ack_seen <= 1'b1;
            if (ack_seen && match.fin_rec) begin
              tcb.loc_ack <= tcb.loc_ack + 1;
              fsm         <= lack_s;
            end
          end
        end
        lack_s: if (can_send) begin
          send <= 1'b1;
          kind <= seg_ack;
          fsm  <= lack_sent_s;
        end
        lack_sent_s: if (sent) begin
          if (pas_cls) begin
            fsm <= fin_s;
          end else begin
            tcb <= '0;
            fsm <= closed_s;
          end
        end
        rst_s: if (can_send) begin
          send <= 1'b1;
          kind <= seg_rst_ack;
          fsm  <= rst_sent_s;
        end
        rst_sent_s: if (sent) begin
          tcb <= '0;
          fsm <= closed_s;
        end
        default: fsm <= closed_s;
      endcase
      if (tmo) begin // open or close took too long
        fsm  <= closed_s;
        tcb  <= '0;
        send <= 1'b0;
      end
    end
  end

  a_send_idle: assert property (@(posedge clk) disable iff (rst_rec)
    $rose(send) |-> !busy);

endmodule

/* tcp_seg_tx.sv */
`timescale 1ns/1ps

module tcp_seg_tx #(
  parameter int WINDOW = 4000
) (
  input  logic                    clk,
  input  logic                    rst_rec,
  input  logic                    send,
  input  tcp_conn_pkg::seg_kind_e kind,
  input  tcp_conn_pkg::tcb_t      tcb,
  input  tcp_conn_pkg::conn_cfg_t cfg,
  output logic                    sent,
  output logic                    busy,
  output tcp_conn_pkg::tx_seg_t   tx_seg,
  output logic                    tx_req,
  input  logic                    tx_ack
);
  import tcp_conn_pkg::*;

  enum logic [2:0] {ph_idle, ph_load, ph_req, ph_rel, ph_done} ph;

  tx_seg_t hdr;

  //////////////////////////////
  // header by kind
  //////////////////////////////
  always_comb begin
    hdr          = '0;
    hdr.dst_ip   = tcb.rem_ip;
    hdr.src_port = tcb.loc_port;
    hdr.dst_port = tcb.rem_port;
    hdr.seq      = tcb.loc_seq;
    hdr.ack      = tcb.loc_ack;
    hdr.wnd      = 16'(WINDOW);
    hdr.offset   = 4'd5; // no options on any kind
    case (kind)
      seg_syn: begin
        hdr.seq       = cfg.loc_isn;
        hdr.ack       = '0;
        hdr.flags.raw = FLAG_SYN;
      end
      seg_syn_ack: hdr.flags.raw = FLAG_SYN | FLAG_ACK;
      seg_ack:     hdr.flags.raw = FLAG_ACK;
      seg_fin_ack: hdr.flags.raw = FLAG_FIN | FLAG_ACK;
      seg_rst_ack: hdr.flags.raw = FLAG_RST | FLAG_ACK;
      default:     hdr.flags.raw = '0;
    endcase
  end

  // four phase handshake
  always_ff @(posedge clk) begin
    if (rst_rec) begin
      ph <= ph_idle;
    end else begin
      case (ph)
        ph_idle: if (send) ph <= ph_load;
        ph_load: ph <= ph_req;              // header settles before req
        ph_req:  if (tx_ack) ph <= ph_rel;
        ph_rel:  if (!tx_ack) ph <= ph_done;
        default: ph <= ph_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ph == ph_idle && send) tx_seg <= hdr; // latched once per request
  end

  assign tx_req = (ph == ph_req);
  assign sent   = (ph == ph_done);
  assign busy   = (ph != ph_idle);

  a_seg_stable: assert property (@(posedge clk) disable iff (rst_rec)
    tx_req |-> $stable(tx_seg));

endmodule

/* tcp_conn_top.sv */
`timescale 1ns/1ps

module tcp_conn_top #(
  parameter int TMR_W  = 32,
  parameter int WINDOW = 4000
) (
  input  logic                  clk,
  input  logic                  rst_rec,
  input  logic                  cfg_wr,
  input  logic [2:0]            cfg_addr,
  input  logic [31:0]           cfg_wdata,
  output logic [31:0]           cfg_rdata,
  input  tcp_conn_pkg::rx_seg_t rx,
  output tcp_conn_pkg::tx_seg_t tx_seg,
  output logic                  tx_req,
  input  logic                  tx_ack
);
  import tcp_conn_pkg::*;

  conn_cfg_t   cfg;
  tcb_t        tcb;
  conn_state_e state;
  seg_match_t  match;
  seg_kind_e   kind;
  logic        send;
  logic        sent;
  logic        busy;

  //////////////////////////////
  // host side
  //////////////////////////////
  tcp_conn_regs u_regs (
    .clk       (clk),
    .rst_rec   (rst_rec),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .state     (state),
    .tcb       (tcb),
    .cfg       (cfg)
  );

  tcp_seg_match u_match (.rx(rx), .cfg(cfg), .tcb(tcb), .match(match));

  tcp_conn_fsm #(.TMR_W(TMR_W)) u_fsm (
    .clk     (clk),
    .rst_rec (rst_rec),
    .cfg     (cfg),
    .match   (match),
    .rx      (rx),
    .sent    (sent),
    .busy    (busy),
    .send    (send),
    .kind    (kind),
    .state   (state),
    .tcb     (tcb)
  );

  tcp_seg_tx #(.WINDOW(WINDOW)) u_tx (
    .clk     (clk),
    .rst_rec (rst_rec),
    .send    (send),
    .kind    (kind),
    .tcb     (tcb),
    .cfg     (cfg),
    .sent    (sent),
    .busy    (busy),
    .tx_seg  (tx_seg),
    .tx_req  (tx_req),
    .tx_ack  (tx_ack)
  );

endmodule

/* tb_tcp_conn.sv */
`timescale 1ns/1ps

module tb_tcp_conn;
  import tcp_conn_pkg::*;

  localparam int CLK_NS    = 40;
  localparam int WINDOW    = 4000;
  localparam int TMO_LONG  = 200;  // cycles, open and close phases
  localparam int TMO_SHORT = 80;   // cycles, timeout test
  localparam int N_SEGS    = 40;   // segments while established
  localparam int N_TESTS   = 6;
  localparam int WAIT_CYC  = 400;
  localparam longint WDOG_NS = longint'(N_TESTS * 4 * TMO_LONG + N_SEGS * 16 + 500) * CLK_NS;
  localparam logic [7:0] FLAG_PSH = 8'h08;

  logic        clk;
  logic        rst_rec;
  logic        cfg_wr;
  logic [2:0]  cfg_addr;
  logic [31:0] cfg_wdata;
  logic [31:0] cfg_rdata;
  rx_seg_t     rx;
  tx_seg_t     tx_seg;
  logic        tx_req;
  logic        tx_ack;

  int err_cnt  = 0;
  int fail_cnt = 0;
  logic [31:0] lfsr = 32'h9ba0_f245;

  // peer model view of the connection
  ipv4_addr_t m_rip;
  tcp_port_t  m_lp;
  tcp_port_t  m_rp;
  tcp_num_t   m_isn;
  tcp_num_t   m_loc_seq;
  tcp_num_t   m_loc_ack;
  tcp_num_t   m_rem_ack;

  tcp_conn_top #(.TMR_W(32), .WINDOW(WINDOW)) u_tcp_conn_top (
    .clk       (clk),
    .rst_rec   (rst_rec),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .rx        (rx),
    .tx_seg    (tx_seg),
    .tx_req    (tx_req),
    .tx_ack    (tx_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic tx_seg_t exp_seg(input logic [7:0] flags, input tcp_num_t seq,
                                      input tcp_num_t ack);
    tx_seg_t s;
    s           = '0;
    s.dst_ip    = m_rip;
    s.src_port  = m_lp;
    s.dst_port  = m_rp;
    s.seq       = seq;
    s.ack       = ack;
    s.flags.raw = flags;
    s.wnd       = 16'(WINDOW);
    s.offset    = 4'd5;
    return s;
  endfunction

  function automatic rx_seg_t peer_seg(input logic [7:0] flags, input tcp_num_t seq,
                                       input tcp_num_t ack, input logic [15:0] pld);
    rx_seg_t s;
    s.val       = 1'b1;
    s.src_ip    = m_rip;
    s.src_port  = m_rp;
    s.dst_port  = m_lp;
    s.seq       = seq;
    s.ack       = ack;
    s.flags.raw = flags;
    s.pld_len   = pld;
    return s;
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic check_seg(input tx_seg_t got, input tx_seg_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s header %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_state(input conn_state_e got, input conn_state_e exp,
                             input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s state %s expected %s", $time, what, got.name(),
               exp.name());
      err_cnt++;
    end
  endtask

  task automatic check_num(input tcp_num_t got, input tcp_num_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  //////////////////////////////
  // host and peer access
  //////////////////////////////
  task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
    @(negedge clk);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_wr = 1'b0;
  endtask

  task automatic reg_read(input logic [2:0] addr, output logic [31:0] data);
    @(negedge clk);
    cfg_addr = addr;
    #(CLK_NS / 4); // mid low phase, rdata settled
    data = cfg_rdata;
  endtask

  task automatic rx_drive(input rx_seg_t seg);
    @(negedge clk);
    rx = seg;
    @(negedge clk);
    rx.val = 1'b0;
  endtask

  task automatic wait_req(input string what);
    int n;
    n = 0;
    while (!tx_req && n < WAIT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (!tx_req) begin
      $display("no segment request came while waiting for %s", what);
      fail_cnt++;
    end
  endtask

  // ack with random delays, then release
  task automatic finish_hs();
    int d;
    int n;
    @(negedge clk);
    d = int'(rand_bits(3));
    repeat (d) @(negedge clk);
    tx_ack = 1'b1;
    n = 0;
    while (tx_req && n < WAIT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (tx_req) begin
      $display("handshake stuck, tx_req stayed high after tx_ack");
      fail_cnt++;
    end
    d = int'(rand_bits(3));
    repeat (d) @(negedge clk);
    tx_ack = 1'b0;
  endtask

  task automatic take_seg(input tx_seg_t exp, input string what);
    wait_req(what);
    check_seg(tx_seg, exp, what);
    finish_hs();
  endtask

  task automatic wait_state(input conn_state_e exp, input string what);
    logic [31:0] v;
    int n;
    n = 0;
    reg_read(REG_STATUS, v);
    while (v[2:0] != exp && n < WAIT_CYC) begin
      reg_read(REG_STATUS, v);
      n++;
    end
    check_state(conn_state_e'(v[2:0]), exp, what);
  endtask

  //////////////////////////////
  // scenarios
  //////////////////////////////
  task automatic active_open();
    tcp_num_t p;
    logic [31:0] v;
    m_rip = rand_bits(32);
    m_lp  = 16'(rand_bits(16));
    m_rp  = 16'(rand_bits(16));
    m_isn = rand_bits(32);
    p     = rand_bits(32);
    reg_write(REG_REM_IP, m_rip);
    reg_write(REG_PORTS, {m_lp, m_rp});
    reg_write(REG_ISN, m_isn);
    reg_write(REG_TIMEOUT, 32'(TMO_LONG));
    reg_write(REG_CTRL, 32'd1);
    take_seg(exp_seg(FLAG_SYN, m_isn, 32'd0), "SYN of active open");
    rx_drive(peer_seg(FLAG_SYN | FLAG_ACK, p, m_isn + 32'd1, 16'd0));
    m_loc_seq = m_isn + 32'd1;
    m_loc_ack = p + 32'd1;
    m_rem_ack = m_isn + 32'd1;
    take_seg(exp_seg(FLAG_ACK, m_loc_seq, m_loc_ack), "ACK of active open");
    wait_state(st_connected, "active open");
    reg_read(REG_REM_ACK, v);
    check_num(v, m_rem_ack, "rem_ack after active open");
  endtask

  task automatic passive_open();
    tcp_num_t p;
    rx_seg_t s;
    logic [31:0] v;
    m_rip = rand_bits(32);
    m_lp  = 16'(rand_bits(16));
    m_rp  = 16'(rand_bits(16));
    m_isn = rand_bits(32);
    p     = rand_bits(32);
    reg_write(REG_PORTS, {m_lp, 16'd0});
    reg_write(REG_ISN, m_isn);
    reg_write(REG_TIMEOUT, 32'(TMO_LONG));
    reg_write(REG_CTRL, 32'd2);
    wait_state(st_listening, "listen");
    s = peer_seg(FLAG_SYN, p, 32'd0, 16'd0);
    s.dst_port = m_lp ^ 16'h8000; // some other port
    rx_drive(s);
    repeat (4) @(negedge clk);
    if (tx_req) begin
      $display("engine answered a SYN sent to another port");
      fail_cnt++;
    end
    wait_state(st_listening, "SYN to wrong port");
    rx_drive(peer_seg(FLAG_SYN, p, 32'd0, 16'd0));
    take_seg(exp_seg(FLAG_SYN | FLAG_ACK, m_isn, p + 32'd1), "SYN-ACK of passive open");
    rx_drive(peer_seg(FLAG_ACK, p + 32'd1, m_isn + 32'd1, 16'd0));
    m_loc_seq = m_isn + 32'd1;
    m_loc_ack = p + 32'd1;
    m_rem_ack = m_isn + 32'd1;
    wait_state(st_connected, "passive open");
    reg_read(REG_LOC_SEQ, v);
    check_num(v, m_loc_seq, "loc_seq after passive open");
    reg_read(REG_REM_ACK, v);
    check_num(v, m_rem_ack, "rem_ack after passive open");
  endtask

  task automatic est_tracking();
    rx_seg_t s;
    logic [31:0] v;
    tcp_num_t seq;
    tcp_num_t ack;
    tcp_num_t off;
    tcp_num_t dif;
    logic [15:0] pld;
    logic in_ord;
    logic fwd;
    logic has_ack;
    logic bad_port;
    for (int i = 0; i < N_SEGS; i++) begin
      in_ord   = (rand_bits(1) != 0);
      fwd      = (rand_bits(1) != 0);
      has_ack  = (rand_bits(2) != 0);
      bad_port = (rand_bits(3) == 0);
      off      = rand_bits(12) + 32'd1;
      ack      = fwd ? m_rem_ack + off : m_rem_ack - off;
      seq      = in_ord ? m_loc_ack : m_loc_ack + 32'd1 + rand_bits(8);
      pld      = 16'(rand_bits(10));
      s = peer_seg(has_ack ? (FLAG_ACK | FLAG_PSH) : FLAG_PSH, seq, ack, pld);
      if (bad_port) s.src_port = m_rp + 16'd1;
      rx_drive(s);
      if (!bad_port && has_ack) begin
        dif = ack - m_rem_ack;
        if (!dif[31]) m_rem_ack = ack; // only moves forward
        if (seq == m_loc_ack) m_loc_ack = m_loc_ack + 32'(pld);
      end
      reg_read(REG_REM_ACK, v);
      check_num(v, m_rem_ack, "rem_ack while established");
    end
    reg_read(REG_LOC_SEQ, v);
    check_num(v, m_loc_seq, "loc_seq while established");
    wait_state(st_connected, "after tracking");
  endtask

  task automatic active_close();
    logic [31:0] v;
    reg_write(REG_CTRL, 32'd0);
    take_seg(exp_seg(FLAG_FIN | FLAG_ACK, m_loc_seq, m_loc_ack), "FIN-ACK of active close");
    rx_drive(peer_seg(FLAG_ACK, m_loc_ack, m_loc_seq + 32'd1, 16'd0));
    rx_drive(peer_seg(FLAG_FIN | FLAG_ACK, m_loc_ack, m_loc_seq + 32'd1, 16'd0));
    m_loc_ack = m_loc_ack + 32'd1;
    take_seg(exp_seg(FLAG_ACK, m_loc_seq, m_loc_ack), "last ACK of active close");
    wait_state(st_closed, "active close");
    reg_read(REG_LOC_SEQ, v);
    check_num(v, 32'd0, "loc_seq after close");
  endtask

  task automatic passive_close();
    rx_drive(peer_seg(FLAG_FIN | FLAG_ACK, m_loc_ack, m_loc_seq, 16'd0));
    m_loc_ack = m_loc_ack + 32'd1; // FIN counts as one
    take_seg(exp_seg(FLAG_ACK, m_loc_seq, m_loc_ack), "ACK of peer FIN");
    take_seg(exp_seg(FLAG_FIN | FLAG_ACK, m_loc_seq, m_loc_ack), "FIN-ACK of passive close");
    reg_write(REG_CTRL, 32'd0); // keep it from listening again
    rx_drive(peer_seg(FLAG_ACK, m_loc_ack, m_loc_seq + 32'd1, 16'd0));
    wait_state(st_closed, "passive close");
  endtask

  task automatic reset_close();
    rx_drive(peer_seg(FLAG_RST | FLAG_ACK, m_loc_ack, m_loc_seq, 16'd0));
    wait_req("RST-ACK");
    check_seg(tx_seg, exp_seg(FLAG_RST | FLAG_ACK, m_loc_seq, m_loc_ack), "RST-ACK");
    reg_write(REG_CTRL, 32'd0);
    finish_hs();
    wait_state(st_closed, "reset close");
  endtask

  // peer stays silent, SYN repeats after each timeout
  task automatic timeout_test();
    m_rip = rand_bits(32);
    m_lp  = 16'(rand_bits(16));
    m_rp  = 16'(rand_bits(16));
    m_isn = rand_bits(32);
    reg_write(REG_REM_IP, m_rip);
    reg_write(REG_PORTS, {m_lp, m_rp});
    reg_write(REG_ISN, m_isn);
    reg_write(REG_TIMEOUT, 32'(TMO_SHORT));
    reg_write(REG_CTRL, 32'd1);
    take_seg(exp_seg(FLAG_SYN, m_isn, 32'd0), "first SYN");
    wait_state(st_closed, "timeout after silent peer");
    wait_req("second SYN");
    check_seg(tx_seg, exp_seg(FLAG_SYN, m_isn, 32'd0), "second SYN");
    wait_state(st_closed, "timeout with SYN stalled"); // tx_ack held low
    finish_hs();
    take_seg(exp_seg(FLAG_SYN, m_isn, 32'd0), "SYN after stall");
    reg_write(REG_CTRL, 32'd0);
    wait_state(st_closed, "final timeout");
  endtask

  initial begin
    #(WDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WDOG_NS);
    $display("Something failed");
    $finish;
  end

  initial begin
    rst_rec   = 1'b1;
    cfg_wr    = 1'b0;
    cfg_addr  = REG_CTRL;
    cfg_wdata = '0;
    rx        = '0;
    tx_ack    = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_rec = 1'b0;
    if (tx_req !== 1'b0) begin
      $display("tx_req not low after reset");
      fail_cnt++;
    end
    wait_state(st_closed, "after reset");

    active_open();
    est_tracking();
    active_close();
    passive_open();
    passive_close();
    active_open();
    reset_close();
    timeout_test();

    $display("tb_tcp_conn: %0d mismatches, %0d failures", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* tcp_conn.f */
tcp_conn_pkg.sv
tcp_conn_regs.sv
tcp_seg_match.sv
tcp_conn_fsm.sv
tcp_seg_tx.sv
tcp_conn_top.sv
tb_tcp_conn.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_tcp_conn \
  -f tcp_conn.f -o tb_tcp_conn
out=$(./obj_dir/tb_tcp_conn)
echo "$out"

if echo "$out" | grep -q "^Everything OK$"; then
  exit 0
else
  exit 1
fi
